// File: source/issue_pkg.sv
package issue_pkg;

  // ****************************************
  // Queue sizing
  // ****************************************

  localparam int queue_depth = 8;
  localparam int ptr_width = 3;   // Wraps at queue_depth
  localparam int count_width = 4; // Holds 0 to queue_depth
  localparam logic [count_width-1:0] stall_level = 4;

  localparam int xlen = 32;

  // addi x0,x0,0
  localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

  // ****************************************
  // Base integer opcodes
  // ****************************************

  localparam logic [6:0] opcode_lui = 7'b0110111;
  localparam logic [6:0] opcode_auipc = 7'b0010111;
  localparam logic [6:0] opcode_jal = 7'b1101111;
  localparam logic [6:0] opcode_jalr = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_load = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;
  localparam logic [6:0] opcode_immediate = 7'b0010011;
  localparam logic [6:0] opcode_register = 7'b0110011;
  localparam logic [6:0] opcode_fence = 7'b0001111;
  localparam logic [6:0] opcode_system = 7'b1110011;

  // ALU function codes, shared by the immediate and register forms
  localparam logic [2:0] funct_add = 3'b000;
  localparam logic [2:0] funct_sll = 3'b001;
  localparam logic [2:0] funct_slt = 3'b010;
  localparam logic [2:0] funct_sltu = 3'b011;
  localparam logic [2:0] funct_xor = 3'b100;
  localparam logic [2:0] funct_srl = 3'b101;
  localparam logic [2:0] funct_or = 3'b110;
  localparam logic [2:0] funct_and = 3'b111;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt = 7'b0100000; // Selects sub and sra

  // ****************************************
  // Instruction word views
  // ****************************************

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm; // Upper seven bits carry the shift type
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } i;
  } instr_word_t;

endpackage

// File: source/queue_if.sv
interface queue_if;

  // Two oldest entries of the queue
  logic [issue_pkg::xlen-1:0] head_pc0;
  logic [issue_pkg::xlen-1:0] head_instr0;
  logic head_valid0;
  logic [issue_pkg::xlen-1:0] head_pc1;
  logic [issue_pkg::xlen-1:0] head_instr1;
  logic head_valid1;

  logic [1:0] take; // Entries consumed this cycle

  modport queue (
    output head_pc0, head_instr0, head_valid0,
    output head_pc1, head_instr1, head_valid1,
    input take
  );

  modport issue (
    input head_pc0, head_instr0, head_valid0,
    input head_pc1, head_instr1, head_valid1,
    output take
  );

endinterface

// File: source/slot_info_if.sv
interface slot_info_if;

  logic basic;
  logic complex;
  logic wren;  // Only with a nonzero rd
  logic rden1;
  logic rden2;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;

  modport decode (
    output basic, complex, wren, rden1, rden2, rd, rs1, rs2
  );

  modport issue (
    input basic, complex, wren, rden1, rden2, rd, rs1, rs2
  );

endinterface

// File: source/fetch_queue.sv
module fetch_queue (
  input  logic        clock,
  input  logic        reset,
  input  logic        clear,
  input  logic        write,
  input  logic [31:0] write_pc,
  input  logic [63:0] write_data,
  output logic        stall,
  queue_if.queue      queue
);

  logic [issue_pkg::xlen-1:0] pc_mem [issue_pkg::queue_depth];
  logic [issue_pkg::xlen-1:0] instr_mem [issue_pkg::queue_depth];

  logic [issue_pkg::ptr_width-1:0] rd_ptr;
  logic [issue_pkg::ptr_width-1:0] rd_ptr_plus;
  logic [issue_pkg::ptr_width-1:0] wr_ptr;
  logic [issue_pkg::ptr_width-1:0] wr_ptr_plus;
  logic [issue_pkg::ptr_width-1:0] take_ptr;

  logic [issue_pkg::count_width-1:0] count;
  logic [issue_pkg::count_width-1:0] count_next;
  logic [issue_pkg::count_width-1:0] take_count;
  logic [issue_pkg::count_width-1:0] fill_count;

  logic accept;

  // A word strobed while stalled is dropped
  assign accept = write && !stall && !clear;

  assign rd_ptr_plus = rd_ptr + {{(issue_pkg::ptr_width-1){1'b0}}, 1'b1};
  assign wr_ptr_plus = wr_ptr + {{(issue_pkg::ptr_width-1){1'b0}}, 1'b1};
  assign take_ptr = {{(issue_pkg::ptr_width-2){1'b0}}, queue.take};

  assign take_count = {{(issue_pkg::count_width-2){1'b0}}, queue.take};
  assign fill_count = {{(issue_pkg::count_width-2){1'b0}}, accept, 1'b0};
  assign count_next = count - take_count + fill_count;

  // ****************************************
  // Head of the queue
  // ****************************************

  assign queue.head_valid0 = count != 0;
  assign queue.head_valid1 = count > 1;

  assign queue.head_pc0 = queue.head_valid0 ? pc_mem[rd_ptr] : '0;
  assign queue.head_pc1 = queue.head_valid1 ? pc_mem[rd_ptr_plus] : '0;
  assign queue.head_instr0 = queue.head_valid0 ? instr_mem[rd_ptr] : issue_pkg::nop_instr;
  assign queue.head_instr1 = queue.head_valid1 ? instr_mem[rd_ptr_plus] : issue_pkg::nop_instr;

  // Low half sits at the word address, high half four bytes on
  always_ff @(posedge clock) begin
    if (accept) begin
      pc_mem[wr_ptr] <= write_pc;
      instr_mem[wr_ptr] <= write_data[31:0];
      pc_mem[wr_ptr_plus] <= write_pc + 32'd4;
      instr_mem[wr_ptr_plus] <= write_data[63:32];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      count <= '0;
      rd_ptr <= '0;
      wr_ptr <= '0;
      stall <= 1'b0;
    end else if (clear) begin
      count <= '0;
      rd_ptr <= '0;
      wr_ptr <= '0;
      stall <= 1'b0;
    end else begin
      count <= count_next;
      rd_ptr <= rd_ptr + take_ptr;
      if (accept) begin
        wr_ptr <= wr_ptr + {{(issue_pkg::ptr_width-2){1'b0}}, 2'd2};
      end
      stall <= count_next > issue_pkg::stall_level; // Occupancy seen after this edge
    end
  end

endmodule

// File: source/instr_classifier.sv
module instr_classifier (
  input issue_pkg::instr_word_t instr,
  slot_info_if.decode           info
);

  logic rd_nonzero;

  assign rd_nonzero = |instr.r.rd;

  // Register fields sit at the same place in every format
  assign info.rd = instr.r.rd;
  assign info.rs1 = instr.r.rs1;
  assign info.rs2 = instr.r.rs2;

  always_comb begin
    info.basic = 1'b0;
    info.complex = 1'b0;
    info.wren = 1'b0;
    info.rden1 = 1'b0;
    info.rden2 = 1'b0;

    case (instr.r.opcode)
      issue_pkg::opcode_lui, issue_pkg::opcode_auipc, issue_pkg::opcode_jal: begin
        info.complex = 1'b1;
        info.wren = rd_nonzero;
      end
      issue_pkg::opcode_jalr, issue_pkg::opcode_load: begin
        info.complex = 1'b1;
        info.wren = rd_nonzero;
        info.rden1 = 1'b1;
      end
      issue_pkg::opcode_branch, issue_pkg::opcode_store: begin
        info.complex = 1'b1;
        info.rden1 = 1'b1;
        info.rden2 = 1'b1;
      end
      issue_pkg::opcode_immediate: begin
        case (instr.i.funct3)
          issue_pkg::funct_add, issue_pkg::funct_slt, issue_pkg::funct_sltu,
          issue_pkg::funct_xor, issue_pkg::funct_or, issue_pkg::funct_and: begin
            info.basic = 1'b1;
          end
          issue_pkg::funct_sll: begin
            info.basic = instr.i.imm[11:5] == issue_pkg::funct7_base;
            info.complex = !info.basic;
          end
          default: begin // Logical and arithmetic right shifts
            info.basic = instr.i.imm[11:5] == issue_pkg::funct7_base ||
                         instr.i.imm[11:5] == issue_pkg::funct7_alt;
            info.complex = !info.basic;
          end
        endcase
        info.wren = rd_nonzero;
        info.rden1 = 1'b1;
      end
      issue_pkg::opcode_register: begin
        if (instr.r.funct7 == issue_pkg::funct7_base) begin
          info.basic = 1'b1; // All eight functions
        end else if (instr.r.funct7 == issue_pkg::funct7_alt) begin
          info.basic = instr.r.funct3 == issue_pkg::funct_add ||
                       instr.r.funct3 == issue_pkg::funct_srl;
          info.complex = !info.basic;
        end else begin
          info.complex = 1'b1;
        end
        info.wren = rd_nonzero;
        info.rden1 = 1'b1;
        info.rden2 = 1'b1;
      end
      issue_pkg::opcode_fence: begin
        info.complex = 1'b1;
      end
      issue_pkg::opcode_system: begin
        info.complex = 1'b1;
        // Any nonzero funct3 writes rd, and only the register CSR forms read rs1
        info.wren = rd_nonzero && instr.r.funct3 != 3'd0;
        info.rden1 = instr.r.funct3 == 3'd1 || instr.r.funct3 == 3'd2 ||
                     instr.r.funct3 == 3'd3;
      end
      default: begin
      end
    endcase
  end

endmodule

// File: source/pair_issue.sv
module pair_issue (
  input  logic        hold,
  queue_if.issue      queue,
  slot_info_if.issue  slot0,
  slot_info_if.issue  slot1,
  output logic [31:0] pc0,
  output logic [31:0] pc1,
  output logic [31:0] npc0,
  output logic [31:0] npc1,
  output logic [31:0] instr0,
  output logic [31:0] instr1,
  output logic        swap
);

  logic [1:0] take;
  logic depends;
  logic pairable;
  logic [issue_pkg::xlen-1:0] head_npc0;
  logic [issue_pkg::xlen-1:0] head_npc1;

  // Slot 1 reads what slot 0 writes
  assign depends = slot0.wren &&
                   ((slot1.rden1 && slot1.rs1 == slot0.rd) ||
                    (slot1.rden2 && slot1.rs2 == slot0.rd));

  assign pairable = (slot0.basic && (slot1.basic || slot1.complex)) ||
                    (slot0.complex && slot1.basic);

  // ****************************************
  // Take count
  // ****************************************

  always_comb begin
    if (hold || !queue.head_valid0) begin
      take = 2'd0;
    end else if (pairable && !depends && queue.head_valid1) begin
      take = 2'd2;
    end else begin
      take = 2'd1;
    end
  end

  assign queue.take = take;

  // Complex work always goes to slot 0
  assign swap = take == 2'd2 && slot0.basic && slot1.complex;

  // Compressed encodings advance by two
  assign head_npc0 = queue.head_pc0 + ((queue.head_instr0[1:0] == 2'b11) ? 32'd4 : 32'd2);
  assign head_npc1 = queue.head_pc1 + ((queue.head_instr1[1:0] == 2'b11) ? 32'd4 : 32'd2);

  always_comb begin
    pc0 = '0;
    npc0 = '0;
    instr0 = issue_pkg::nop_instr;
    pc1 = '0;
    npc1 = '0;
    instr1 = issue_pkg::nop_instr;
    if (take != 2'd0) begin
      pc0 = swap ? queue.head_pc1 : queue.head_pc0;
      npc0 = swap ? head_npc1 : head_npc0;
      instr0 = swap ? queue.head_instr1 : queue.head_instr0;
    end
    if (take == 2'd2) begin
      pc1 = swap ? queue.head_pc0 : queue.head_pc1;
      npc1 = swap ? head_npc0 : head_npc1;
      instr1 = swap ? queue.head_instr0 : queue.head_instr1;
    end
  end

endmodule

// File: source/issue_top.sv
module issue_top (
  input  logic        clock,
  input  logic        reset,
  input  logic        clear,
  input  logic        fetch_ready,
  input  logic [31:0] fetch_pc,
  input  logic [63:0] fetch_data,
  input  logic        hold,
  output logic        stall,
  output logic        swap,
  output logic [31:0] pc0,
  output logic [31:0] pc1,
  output logic [31:0] npc0,
  output logic [31:0] npc1,
  output logic [31:0] instr0,
  output logic [31:0] instr1
);

  queue_if queue_bus ();
  slot_info_if slot0_info ();
  slot_info_if slot1_info ();

  fetch_queue fetch_queue_inst (
    .clock      (clock),
    .reset      (reset),
    .clear      (clear),
    .write      (fetch_ready),
    .write_pc   (fetch_pc),
    .write_data (fetch_data),
    .stall      (stall),
    .queue      (queue_bus)
  );

  // One decoder per head entry
  instr_classifier classifier0_inst (
    .instr (queue_bus.head_instr0),
    .info  (slot0_info)
  );

  instr_classifier classifier1_inst (
    .instr (queue_bus.head_instr1),
    .info  (slot1_info)
  );

  pair_issue pair_issue_inst (
    .hold   (hold),
    .queue  (queue_bus),
    .slot0  (slot0_info),
    .slot1  (slot1_info),
    .pc0    (pc0),
    .pc1    (pc1),
    .npc0   (npc0),
    .npc1   (npc1),
    .instr0 (instr0),
    .instr1 (instr1),
    .swap   (swap)
  );

endmodule

// File: sim/issue_vectors.svh
// Each row holds clear, fetch_ready, fetch_pc, fetch_data {high, low} and hold, then the
// expected stall, swap, pc0, pc1, npc0, npc1, instr0 and instr1 for the same cycle
`ifndef ISSUE_VECTORS_SVH
`define ISSUE_VECTORS_SVH

localparam int vector_count = 25;

vector_t vectors [vector_count] = '{
  // Idle after reset
  '{1'b0, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b0, 1'b0, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013},
  // add x1,x2,x3 and xori x4,x5,1 pair up one cycle after the write
  '{1'b0, 1'b1, 32'h00000100, 64'h0012c213_003100b3, 1'b0, 1'b0, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013},
  '{1'b0, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b0, 1'b0, 1'b0,
    32'h00000100, 32'h00000104, 32'h00000104, 32'h00000108, 32'h003100b3, 32'h0012c213},
  // xori x4,x1,1 reads x1 and has to wait a cycle
  '{1'b0, 1'b1, 32'h00000200, 64'h0010c213_003100b3, 1'b0, 1'b0, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013},
  '{1'b0, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b0, 1'b0, 1'b0,
    32'h00000200, 32'h00000000, 32'h00000204, 32'h00000000, 32'h003100b3, 32'h00000013},
  '{1'b0, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b0, 1'b0, 1'b0,
    32'h00000204, 32'h00000000, 32'h00000208, 32'h00000000, 32'h0010c213, 32'h00000013},
  // With x0 as the destination there is no dependency
  '{1'b0, 1'b1, 32'h00000300, 64'h00104213_00310033, 1'b0, 1'b0, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013},
  '{1'b0, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b0, 1'b0, 1'b0,
    32'h00000300, 32'h00000304, 32'h00000304, 32'h00000308, 32'h00310033, 32'h00104213},
  // add then lw x5,0(x6) swaps the load into slot 0
  '{1'b0, 1'b1, 32'h00000400, 64'h00032283_003100b3, 1'b0, 1'b0, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013},
  '{1'b0, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b0, 1'b0, 1'b1,
    32'h00000404, 32'h00000400, 32'h00000408, 32'h00000404, 32'h00032283, 32'h003100b3},
  '{1'b0, 1'b1, 32'h00000500, 64'h003100b3_00032283, 1'b0, 1'b0, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013},
  '{1'b0, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b0, 1'b0, 1'b0,
    32'h00000500, 32'h00000504, 32'h00000504, 32'h00000508, 32'h00032283, 32'h003100b3},
  // Load and lui x7 are both complex
  '{1'b0, 1'b1, 32'h00000600, 64'h123453b7_00032283, 1'b0, 1'b0, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013},
  '{1'b0, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b0, 1'b0, 1'b0,
    32'h00000600, 32'h00000000, 32'h00000604, 32'h00000000, 32'h00032283, 32'h00000013},
  '{1'b0, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b0, 1'b0, 1'b0,
    32'h00000604, 32'h00000000, 32'h00000608, 32'h00000000, 32'h123453b7, 32'h00000013},
  // Three words under hold, stall once six entries wait
  '{1'b0, 1'b1, 32'h00000700, 64'h0012c213_003100b3, 1'b1, 1'b0, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013},
  '{1'b0, 1'b1, 32'h00000708, 64'h0012c213_003100b3, 1'b1, 1'b0, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013},
  '{1'b0, 1'b1, 32'h00000710, 64'h0012c213_003100b3, 1'b1, 1'b0, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013},
  '{1'b0, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b1, 1'b1, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013},
  '{1'b1, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b1, 1'b1, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013},
  '{1'b0, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b0, 1'b0, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013},
  // A 16-bit style word in the low half advances by two
  '{1'b0, 1'b1, 32'h00000800, 64'h003100b3_00000001, 1'b0, 1'b0, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013},
  '{1'b0, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b0, 1'b0, 1'b0,
    32'h00000800, 32'h00000000, 32'h00000802, 32'h00000000, 32'h00000001, 32'h00000013},
  '{1'b0, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b0, 1'b0, 1'b0,
    32'h00000804, 32'h00000000, 32'h00000808, 32'h00000000, 32'h003100b3, 32'h00000013},
  '{1'b0, 1'b0, 32'h00000000, 64'h00000000_00000000, 1'b0, 1'b0, 1'b0,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000013, 32'h00000013}
};

`endif

// File: sim/issue_tb.sv
module issue_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int reset_timeout = 10;

  typedef struct packed {
    logic clear;
    logic fetch_ready;
    logic [31:0] fetch_pc;
    logic [63:0] fetch_data;
    logic hold;
    logic stall;
    logic swap;
    logic [31:0] pc0;
    logic [31:0] pc1;
    logic [31:0] npc0;
    logic [31:0] npc1;
    logic [31:0] instr0;
    logic [31:0] instr1;
  } vector_t;

  `include "issue_vectors.svh"

  logic clock;
  logic reset;
  logic clear;
  logic fetch_ready;
  logic [31:0] fetch_pc;
  logic [63:0] fetch_data;
  logic hold;
  logic stall;
  logic swap;
  logic [31:0] pc0;
  logic [31:0] pc1;
  logic [31:0] npc0;
  logic [31:0] npc1;
  logic [31:0] instr0;
  logic [31:0] instr1;

  int row; // Table row under test

  issue_top DUT (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .fetch_ready (fetch_ready),
    .fetch_pc    (fetch_pc),
    .fetch_data  (fetch_data),
    .hold        (hold),
    .stall       (stall),
    .swap        (swap),
    .pc0         (pc0),
    .pc1         (pc1),
    .npc0        (npc0),
    .npc1        (npc1),
    .instr0      (instr0),
    .instr1      (instr1)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // ****************************************
  // Drive and compare
  // ****************************************

  task automatic drive_row(input vector_t v);
    clear = v.clear;
    fetch_ready = v.fetch_ready;
    fetch_pc = v.fetch_pc;
    fetch_data = v.fetch_data;
    hold = v.hold;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected) else begin
      $display("CHECK FAILED at %0t ns, row %0d: %s expected 0x%h, actual 0x%h",
               $time, row, name, expected, actual);
      $display("Test FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_row(input vector_t v);
    check_value("stall", {31'd0, stall}, {31'd0, v.stall});
    check_value("swap", {31'd0, swap}, {31'd0, v.swap});
    check_value("pc0", pc0, v.pc0);
    check_value("pc1", pc1, v.pc1);
    check_value("npc0", npc0, v.npc0);
    check_value("npc1", npc1, v.npc1);
    check_value("instr0", instr0, v.instr0);
    check_value("instr1", instr1, v.instr1);
  endtask

  initial begin
    int wait_cycles;

    reset = 1'b0;
    clear = 1'b0;
    fetch_ready = 1'b0;
    fetch_pc = 32'd0;
    fetch_data = 64'd0;
    hold = 1'b0;
    row = -1;

    repeat (4) @(posedge clock);
    #1 reset = 1'b1;

    // The queue has to come up empty and unstalled
    wait_cycles = 0;
    while (stall !== 1'b0 || instr0 !== issue_pkg::nop_instr) begin
      if (wait_cycles == reset_timeout) begin
        $display("The DUT did not reach its idle state after reset");
        $display("Test FAILED");
        $fatal(1, "reset timeout");
      end
      @(posedge clock);
      wait_cycles++;
    end

    for (int i = 0; i < vector_count; i++) begin
      @(posedge clock);
      row = i;
      #1 drive_row(vectors[i]);
      #2.5 check_row(vectors[i]); // Half a nanosecond before the next edge
    end

    $display("Test OK");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+sim
source/issue_pkg.sv
source/queue_if.sv
source/slot_info_if.sv
source/fetch_queue.sv
source/instr_classifier.sv
source/pair_issue.sv
source/issue_top.sv
sim/issue_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module issue_tb -Mdir obj_dir -f vlog.f

./obj_dir/Vissue_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test OK$" sim.log; then
  exit 0
fi
exit 1
